/* verilog/matGeomPkg.sv */
package matGeomPkg;

	// tile geometry
	parameter int tileDim = 3;                  // tile edge in words
	parameter int tileWords = tileDim * tileDim; // elements per tile

	// default top-level widths
	parameter int dataWDef = 16;
	parameter int addrWDef = 10;

	// types at the default widths
	typedef logic [dataWDef-1:0] wordT;
	typedef logic [addrWDef-1:0] addrT;
	typedef wordT tileT [tileWords]; // row-major inside the tile

	// row-major element order inside a tile
	function automatic int tileIdx(input int row, input int col);
		return row * tileDim + col;
	endfunction

	function automatic int tileRow(input int idx);
		return idx / tileDim;
	endfunction

	function automatic int tileCol(input int idx);
		return idx % tileDim;
	endfunction

endpackage

/* verilog/matCtrlPkg.sv */
package matCtrlPkg;

	// operations on the tile pipeline
	typedef enum logic [1:0] {
		opClear = 2'd0, // zero the accumulator
		opLoadA = 2'd1, // latch an A tile
		opMulB  = 2'd2, // acc += A tile * B tile
		opStore = 2'd3  // write the accumulator back
	} tileOpT;

	typedef enum logic [1:0] {
		sIdle  = 2'd0,
		sRun   = 2'd1,
		sDrain = 2'd2  // let the last store land
	} seqStateT;

	// host register map, low address bits
	typedef enum logic [2:0] {
		rCtrl   = 3'd0,
		rStatus = 3'd1,
		rN      = 3'd2,
		rM      = 3'd3,
		rP      = 3'd4,
		rBBase  = 3'd5,
		rCBase  = 3'd6
	} regSelT;

endpackage

/* verilog/tileBusIf.sv */
`timescale 1ns/1ps

// one tile operation per cycle, valid only, no back-pressure
interface tileBusIf #(
	parameter int dataW = matGeomPkg::dataWDef,
	parameter int addrW = matGeomPkg::addrWDef
);
	import matGeomPkg::*;
	import matCtrlPkg::*;

	logic valid;
	tileOpT op;
	logic [addrW-1:0] base;    // address of the tile's top-left word
	logic [addrW-1:0] stride;  // words per matrix row
	logic [dataW-1:0] tile [tileWords]; // row-major

	modport src (
		output valid, op, base, stride, tile
	);

	modport dst (
		input valid, op, base, stride, tile
	);

endinterface

/* verilog/hostPort.sv */
`timescale 1ns/1ps

module hostPort #(
	parameter int dataW = matGeomPkg::dataWDef,
	parameter int addrW = matGeomPkg::addrWDef
) (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [addrW:0] wbAdr,
	input logic [dataW-1:0] wbDatW,
	output logic [dataW-1:0] wbDatR,
	output logic wbAck,
	input logic busy,
	output logic start,
	output logic [addrW-1:0] n,
	output logic [addrW-1:0] m,
	output logic [addrW-1:0] p,
	output logic [addrW-1:0] bBase,
	output logic [addrW-1:0] cBase,
	output logic [addrW-1:0] memAddr,
	output logic memWe,
	output logic memRe,
	output logic [dataW-1:0] memWData,
	input logic [dataW-1:0] memRData
);
	import matCtrlPkg::*;

	logic isReg;   // top address bit picks the register map
	logic req;     // access taken this cycle
	logic ackReg;  // current ack belongs to a register access
	regSelT sel;
	logic [dataW-1:0] regRData;

	assign isReg = wbAdr[addrW];
	assign sel = regSelT'(wbAdr[2:0]);
	// memory side waits until the engine is idle
	assign req = wbCyc && wbStb && !wbAck && (isReg || !busy);

	// memory word port, one-cycle strobe
	assign memAddr = wbAdr[addrW-1:0];
	assign memWData = wbDatW;
	assign memWe = req && !isReg && wbWe;
	assign memRe = req && !isReg && !wbWe;  // data lands with ack

	assign wbDatR = ackReg ? regRData : memRData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			ackReg <= 1'b0;
			start <= 1'b0;
			n <= '0;
			m <= '0;
			p <= '0;
			bBase <= '0;
			cBase <= '0;
			regRData <= '0;
		end else begin
			wbAck <= req;
			ackReg <= req && isReg;
			start <= req && isReg && wbWe && sel == rCtrl && wbDatW[0]; // one-cycle pulse
			if (req && isReg && wbWe) begin
				case (sel)
					rN: n <= addrW'(wbDatW);
					rM: m <= addrW'(wbDatW);
					rP: p <= addrW'(wbDatW);
					rBBase: bBase <= addrW'(wbDatW);
					rCBase: cBase <= addrW'(wbDatW);
					default: ; // rCtrl only strobes
				endcase
			end
			if (req && isReg && !wbWe) begin
				case (sel)
					rStatus: regRData <= dataW'(busy);
					rN: regRData <= dataW'(n);
					rM: regRData <= dataW'(m);
					rP: regRData <= dataW'(p);
					rBBase: regRData <= dataW'(bBase);
					rCBase: regRData <= dataW'(cBase);
					default: regRData <= '0;
				endcase
			end
		end
	end

	// classic slave: ack only inside an active master cycle
	assert property (@(posedge clk) disable iff (!rstN) wbAck |-> (wbCyc && wbStb))
		else $error("wbAck outside of a bus cycle");

endmodule

/* verilog/tileSequencer.sv */
`timescale 1ns/1ps

module tileSequencer #(
	parameter int dataW = matGeomPkg::dataWDef,
	parameter int addrW = matGeomPkg::addrWDef
) (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic [addrW-1:0] n,
	input logic [addrW-1:0] m,
	input logic [addrW-1:0] p,
	input logic [addrW-1:0] bBase,
	input logic [addrW-1:0] cBase,
	output logic busy,
	tileBusIf.src issue
);
	import matGeomPkg::*;
	import matCtrlPkg::*;

	localparam logic [addrW-1:0] step = addrW'(tileDim);

	seqStateT state;
	tileOpT phase;             // next op for the current C tile
	logic [addrW-1:0] iCnt;    // C tile row, in words
	logic [addrW-1:0] jCnt;    // C tile column, in words
	logic [addrW-1:0] kCnt;    // inner dimension, in words
	logic [addrW-1:0] aCur;
	logic [addrW-1:0] aRow;    // A tile at k = 0 of this tile row
	logic [addrW-1:0] bCur;
	logic [addrW-1:0] bCol;    // B tile at k = 0 of this tile column
	logic [addrW-1:0] cCur;
	logic [addrW-1:0] bDown;   // one tile row down in B
	logic [1:0] drainCnt;
	logic lastI;
	logic lastJ;
	logic lastK;

	assign bDown = (p << 1) + p;
	assign lastI = (iCnt + step) == n;
	assign lastJ = (jCnt + step) == p;
	assign lastK = (kCnt + step) == m;
	assign busy = state != sIdle;
	assign issue.tile = '{default: '0};  // no payload on the issue side

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= sIdle;
			phase <= opClear;
			{iCnt, jCnt, kCnt} <= '0;
			{aCur, aRow, bCur, bCol, cCur} <= '0;
			drainCnt <= '0;
			issue.valid <= 1'b0;
			issue.op <= opClear;
			issue.base <= '0;
			issue.stride <= '0;
		end else begin
			issue.valid <= state == sRun;
			case (state)
				sIdle: if (start) begin
					state <= sRun;
					phase <= opClear;
					{iCnt, jCnt, kCnt} <= '0;
					aCur <= '0;   // A sits at word 0
					aRow <= '0;
					bCur <= bBase;
					bCol <= bBase;
					cCur <= cBase;
				end
				sRun: begin
					issue.op <= phase;
					case (phase)
						opClear: begin
							issue.base <= cCur;
							issue.stride <= p;
							phase <= opLoadA;
						end
						opLoadA: begin
							issue.base <= aCur;
							issue.stride <= m;  // A rows are m long
							phase <= opMulB;
						end
						opMulB: begin
							issue.base <= bCur;
							issue.stride <= p;
							if (lastK) begin
								phase <= opStore;
								kCnt <= '0;
							end else begin
								phase <= opLoadA;
								kCnt <= kCnt + step;
								aCur <= aCur + step;   // right along A
								bCur <= bCur + bDown;  // down along B
							end
						end
						opStore: begin
							issue.base <= cCur;
							issue.stride <= p;
							phase <= opClear;
							if (lastJ) begin
								// end of a tile row: skip the two rows below it
								jCnt <= '0;
								aCur <= aCur + step + (m << 1);
								aRow <= aCur + step + (m << 1);
								bCur <= bBase;
								bCol <= bBase;
								cCur <= cCur + step + (p << 1);
								iCnt <= iCnt + step;
								if (lastI)
									state <= sDrain;
							end else begin
								jCnt <= jCnt + step;
								aCur <= aRow;  // rewind A to the row start
								bCur <= bCol + step;
								bCol <= bCol + step;
								cCur <= cCur + step;
							end
						end
						default: ;
					endcase
				end
				sDrain: begin
					// exec, write-back, then the memory write
					drainCnt <= drainCnt + 2'd1;
					if (drainCnt == 2'd2) begin
						drainCnt <= '0;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) (start && state == sIdle) |->
		(n != '0 && m != '0 && p != '0 &&
		n % tileDim == 0 && m % tileDim == 0 && p % tileDim == 0))
		else $error("matrix sizes must be nonzero multiples of the tile edge");

endmodule

/* verilog/tileMemory.sv */
`timescale 1ns/1ps

module tileMemory #(
	parameter int dataW = matGeomPkg::dataWDef,
	parameter int addrW = matGeomPkg::addrWDef
) (
	input logic clk,
	tileBusIf.dst issue,
	tileBusIf.src exec,
	input logic storeValid,
	input logic [addrW-1:0] storeBase,
	input logic [addrW-1:0] storeStride,
	input logic [dataW-1:0] storeTile [matGeomPkg::tileWords],
	input logic [addrW-1:0] memAddr,
	input logic memWe,
	input logic memRe,
	input logic [dataW-1:0] memWData,
	output logic [dataW-1:0] memRData
);
	import matGeomPkg::*;

	localparam int depth = 2 ** addrW;

	logic [dataW-1:0] mem [depth];
	logic [addrW-1:0] rdAddr [tileWords];  // read tile element addresses
	logic [addrW-1:0] wrAddr [tileWords];  // write-back element addresses
	logic [addrW+1:0] issueTop;            // last element, unwrapped
	logic [addrW+1:0] storeTop;

	// base + row * stride + col
	function automatic logic [addrW-1:0] elemAddr(input logic [addrW-1:0] base,
		input logic [addrW-1:0] stride, input int idx);
		return base + addrW'(tileRow(idx)) * stride + addrW'(tileCol(idx));
	endfunction

	function automatic logic [addrW+1:0] lastElem(input logic [addrW-1:0] base,
		input logic [addrW-1:0] stride);
		return {2'b00, base} + {1'b0, stride, 1'b0} + (addrW+2)'(tileDim - 1);
	endfunction

	always_comb begin
		for (int w = 0; w < tileWords; w++) begin
			rdAddr[w] = elemAddr(issue.base, issue.stride, w);
			wrAddr[w] = elemAddr(storeBase, storeStride, w);
		end
	end

	assign issueTop = lastElem(issue.base, issue.stride);
	assign storeTop = lastElem(storeBase, storeStride);

	// read stage, op fields travel with the data
	always_ff @(posedge clk) begin
		exec.valid <= issue.valid;
		exec.op <= issue.op;
		exec.base <= issue.base;
		exec.stride <= issue.stride;
		for (int w = 0; w < tileWords; w++)
			exec.tile[w] <= mem[rdAddr[w]];
	end

	// write-back tile and host word share the array, never the same cycle
	always_ff @(posedge clk) begin
		if (storeValid) begin
			for (int w = 0; w < tileWords; w++)
				mem[wrAddr[w]] <= storeTile[w];
		end
		if (memWe)
			mem[memAddr] <= memWData;
		if (memRe)
			memRData <= mem[memAddr];
	end

	assert property (@(posedge clk) issue.valid |-> issueTop[addrW+1:addrW] == 2'b00)
		else $error("tile read runs past the memory end");
	assert property (@(posedge clk) storeValid |-> storeTop[addrW+1:addrW] == 2'b00)
		else $error("tile write runs past the memory end");
	// host is held off while the engine runs
	assert property (@(posedge clk) (memWe || memRe) |-> !storeValid && !issue.valid)
		else $error("host access collides with the engine");

endmodule

/* verilog/tileMac.sv */
`timescale 1ns/1ps

module tileMac #(
	parameter int dataW = matGeomPkg::dataWDef,
	parameter int addrW = matGeomPkg::addrWDef
) (
	input logic clk,
	input logic rstN,
	tileBusIf.dst exec,
	output logic storeValid,
	output logic [addrW-1:0] storeBase,
	output logic [addrW-1:0] storeStride,
	output logic [dataW-1:0] storeTile [matGeomPkg::tileWords]
);
	import matGeomPkg::*;
	import matCtrlPkg::*;

	logic [dataW-1:0] aTile [tileWords];   // latched A tile
	logic [dataW-1:0] acc [tileWords];     // C tile partial sums
	logic [dataW-1:0] macSum [tileWords];  // acc + A * B, wraps at dataW
	int ij;

	always_comb begin
		ij = 0;
		for (int r = 0; r < tileDim; r++) begin
			for (int c = 0; c < tileDim; c++) begin
				ij = tileIdx(r, c);
				macSum[ij] = acc[ij];
				for (int k = 0; k < tileDim; k++) begin
					macSum[ij] = macSum[ij] +
						aTile[tileIdx(r, k)] * exec.tile[tileIdx(k, c)];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			storeValid <= 1'b0;
		else
			storeValid <= exec.valid && exec.op == opStore;  // one cycle on the link
	end

	always_ff @(posedge clk) begin
		if (exec.valid) begin
			case (exec.op)
				opClear: acc <= '{default: '0};
				opLoadA: aTile <= exec.tile;
				opMulB: acc <= macSum;
				opStore: begin
					storeTile <= acc;
					storeBase <= exec.base;
					storeStride <= exec.stride;
				end
				default: ;
			endcase
		end
	end

	// every B tile pairs with the A tile loaded just before it
	assert property (@(posedge clk) disable iff (!rstN)
		(exec.valid && exec.op == opMulB) |-> $past(exec.valid && exec.op == opLoadA))
		else $error("opMulB without a preceding opLoadA");

endmodule

/* verilog/matMulTop.sv */
`timescale 1ns/1ps

module matMulTop #(
	parameter int dataW = matGeomPkg::dataWDef,
	parameter int addrW = matGeomPkg::addrWDef
) (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [addrW:0] wbAdr,
	input logic [dataW-1:0] wbDatW,
	output logic [dataW-1:0] wbDatR,
	output logic wbAck,
	output logic busy
);
	import matGeomPkg::*;

	logic start;
	logic [addrW-1:0] n;
	logic [addrW-1:0] m;
	logic [addrW-1:0] p;
	logic [addrW-1:0] bBase;
	logic [addrW-1:0] cBase;
	logic [addrW-1:0] memAddr;
	logic memWe;
	logic memRe;
	logic [dataW-1:0] memWData;
	logic [dataW-1:0] memRData;
	logic storeValid;          // write-back link, tileMac to tileMemory
	logic [addrW-1:0] storeBase;
	logic [addrW-1:0] storeStride;
	logic [dataW-1:0] storeTile [tileWords];

	tileBusIf #(.dataW(dataW), .addrW(addrW)) issueBus ();  // sequencer to memory
	tileBusIf #(.dataW(dataW), .addrW(addrW)) execBus ();   // memory to MAC

	hostPort #(.dataW(dataW), .addrW(addrW)) i_hostPort (
		.clk(clk), .rstN(rstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.busy(busy), .start(start),
		.n(n), .m(m), .p(p), .bBase(bBase), .cBase(cBase),
		.memAddr(memAddr), .memWe(memWe), .memRe(memRe),
		.memWData(memWData), .memRData(memRData)
	);

	tileSequencer #(.dataW(dataW), .addrW(addrW)) i_tileSequencer (
		.clk(clk), .rstN(rstN), .start(start),
		.n(n), .m(m), .p(p), .bBase(bBase), .cBase(cBase),
		.busy(busy), .issue(issueBus.src)
	);

	tileMemory #(.dataW(dataW), .addrW(addrW)) i_tileMemory (
		.clk(clk), .issue(issueBus.dst), .exec(execBus.src),
		.storeValid(storeValid), .storeBase(storeBase),
		.storeStride(storeStride), .storeTile(storeTile),
		.memAddr(memAddr), .memWe(memWe), .memRe(memRe),
		.memWData(memWData), .memRData(memRData)
	);

	tileMac #(.dataW(dataW), .addrW(addrW)) i_tileMac (
		.clk(clk), .rstN(rstN), .exec(execBus.dst),
		.storeValid(storeValid), .storeBase(storeBase),
		.storeStride(storeStride), .storeTile(storeTile)
	);

endmodule

/* test/matMulTb.sv */
`timescale 1ns/1ps

module matMulTb;
	localparam int dataW = 16;
	localparam int addrW = 10;
	localparam int waitLimit = 500;  // cycles, per wait loop
	localparam logic [2:0] regCtrl = 3'd0;
	localparam logic [2:0] regStatus = 3'd1;
	localparam logic [2:0] regN = 3'd2;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [addrW:0] wbAdr;
	logic [dataW-1:0] wbDatW;
	logic [dataW-1:0] wbDatR;
	logic wbAck;
	logic busy;

	logic [15:0] lfsr;
	int checks;
	int errors;
	int nS, mS, pS, bB, cB;  // current run geometry
	int idx;
	logic busyAtAck;  // busy seen in the ack cycle
	logic [dataW-1:0] rd;
	logic [dataW-1:0] aMat [81];
	logic [dataW-1:0] bMat [81];
	logic [dataW-1:0] cExp [81];
	logic [dataW-1:0] regVal [5];
	logic [addrW:0] memAdr [8];
	logic [dataW-1:0] memVal [8];

	matMulTop #(.dataW(dataW), .addrW(addrW)) i_dut (
		.clk(clk), .rstN(rstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] randBits(input int nb);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nb; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [addrW:0] regAdr(input logic [2:0] sel);
		return {1'b1, {(addrW-3){1'b0}}, sel};  // top bit selects registers
	endfunction

	task automatic abortOnTimeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	task automatic checkEq(input string name, input logic [dataW-1:0] expected,
		input logic [dataW-1:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// one classic cycle, entered and left on a falling edge
	task automatic busAccess(input logic we, input logic [addrW:0] adr,
		input logic [dataW-1:0] dat, output logic [dataW-1:0] rdata);
		int t;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = dat;
		t = 0;
		@(negedge clk);
		while (!wbAck) begin
			t++;
			if (t > waitLimit)
				abortOnTimeout("wishbone ack");
			@(negedge clk);
		end
		rdata = wbDatR;    // valid with ack
		busyAtAck = busy;
		@(negedge clk);    // hold stb over the ack edge
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input logic [addrW:0] adr, input logic [dataW-1:0] dat);
		logic [dataW-1:0] unused;
		busAccess(1'b1, adr, dat, unused);
	endtask

	task automatic wbRead(input logic [addrW:0] adr, output logic [dataW-1:0] dat);
		busAccess(1'b0, adr, '0, dat);
	endtask

	task automatic waitIdle();
		int t;
		t = 0;
		while (busy) begin
			t++;
			if (t > waitLimit)
				abortOnTimeout("busy to fall");
			@(negedge clk);
		end
	endtask

	// C = A * B, wrapped to dataW
	task automatic computeModel();
		longint acc;
		for (int i = 0; i < nS; i++) begin
			for (int j = 0; j < pS; j++) begin
				acc = 0;
				for (int k = 0; k < mS; k++)
					acc = acc + longint'(aMat[i*mS+k]) * longint'(bMat[k*pS+j]);
				cExp[i*pS+j] = dataW'(acc % (longint'(1) << dataW));
			end
		end
	endtask

	task automatic prepareRun(input bit big);
		for (int i = 0; i < nS * mS; i++) begin
			aMat[i] = dataW'(randBits(dataW)) | (big ? 16'hC000 : 16'h0000);
			wbWrite((addrW+1)'(i), aMat[i]);  // A from word 0
		end
		for (int i = 0; i < mS * pS; i++) begin
			bMat[i] = dataW'(randBits(dataW)) | (big ? 16'hC000 : 16'h0000);
			wbWrite((addrW+1)'(bB + i), bMat[i]);
		end
		wbWrite(regAdr(regN), dataW'(nS));
		wbWrite(regAdr(regN + 3'd1), dataW'(mS));
		wbWrite(regAdr(regN + 3'd2), dataW'(pS));
		wbWrite(regAdr(regN + 3'd3), dataW'(bB));
		wbWrite(regAdr(regN + 3'd4), dataW'(cB));
		computeModel();
	endtask

	task automatic startRun();
		wbWrite(regAdr(regCtrl), 16'd1);
		checkEq("busy after start", 16'd1, dataW'(busy));
	endtask

	task automatic checkResult(input string name, input bit withAB);
		waitIdle();
		for (int i = 0; i < nS * pS; i++) begin
			wbRead((addrW+1)'(cB + i), rd);
			checkEq($sformatf("%s C[%0d]", name, i), cExp[i], rd);
		end
		if (withAB) begin
			for (int i = 0; i < nS * mS; i++) begin
				wbRead((addrW+1)'(i), rd);
				checkEq($sformatf("%s A[%0d]", name, i), aMat[i], rd);
			end
			for (int i = 0; i < mS * pS; i++) begin
				wbRead((addrW+1)'(bB + i), rd);
				checkEq($sformatf("%s B[%0d]", name, i), bMat[i], rd);
			end
		end
	endtask

	task automatic pickSizes();
		nS = 3 * (1 + int'(randBits(2)) % 3);  // 3, 6 or 9
		mS = 3 * (1 + int'(randBits(2)) % 3);
		pS = 3 * (1 + int'(randBits(2)) % 3);
		bB = 128 + int'(randBits(6));  // above the largest A
		cB = 320 + int'(randBits(7));  // above the largest B
	endtask

	initial begin
		lfsr = 16'd96;
		checks = 0;
		errors = 0;
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		// register readback, rN up to rCBase
		for (int r = 0; r < 5; r++) begin
			regVal[r] = dataW'(randBits(addrW));
			wbWrite(regAdr(regN + 3'(r)), regVal[r]);
		end
		for (int r = 0; r < 5; r++) begin
			wbRead(regAdr(regN + 3'(r)), rd);
			checkEq($sformatf("register %0d readback", r + 2), regVal[r], rd);
		end
		wbRead(regAdr(regStatus), rd);
		checkEq("status idle", 16'd0, rd);

		// memory words, one per 128-word block
		for (int w = 0; w < 8; w++) begin
			memAdr[w] = (addrW+1)'(w * 128 + int'(randBits(7)));
			memVal[w] = dataW'(randBits(dataW));
			wbWrite(memAdr[w], memVal[w]);
		end
		for (int w = 0; w < 8; w++) begin
			wbRead(memAdr[w], rd);
			checkEq($sformatf("memory word %0d", w), memVal[w], rd);
		end

		// single tile
		nS = 3;
		mS = 3;
		pS = 3;
		bB = 200;
		cB = 400;
		prepareRun(1'b0);
		startRun();
		checkResult("single tile", 1'b0);

		repeat (4) begin
			pickSizes();
			prepareRun(1'b0);
			startRun();
			checkResult($sformatf("sizes %0dx%0dx%0d", nS, mS, pS), 1'b1);
		end

		// big operands, products wrap
		repeat (2) begin
			pickSizes();
			prepareRun(1'b1);
			startRun();
			checkResult("overflow", 1'b0);
		end

		// read during a run is held until busy falls
		nS = 6;
		mS = 6;
		pS = 6;
		bB = 128;
		cB = 320;
		prepareRun(1'b0);
		startRun();
		idx = int'(randBits(6)) % 36;
		wbRead((addrW+1)'(cB + idx), rd);
		checkEq("busy at held ack", 16'd0, dataW'(busyAtAck));
		checkEq($sformatf("held read C[%0d]", idx), cExp[idx], rd);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* compile.f */
verilog/matGeomPkg.sv
verilog/matCtrlPkg.sv
verilog/tileBusIf.sv
verilog/hostPort.sv
verilog/tileSequencer.sv
verilog/tileMemory.sv
verilog/tileMac.sv
verilog/matMulTop.sv
test/matMulTb.sv

/* Makefile */
TOP = matMulTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
